// ==== src/cfg_pkg.sv ====
// --------------------------------------------------------------------------
// shared timing, frame layout and table for the HDMI transmitter setup
// the bus is write only; acknowledge slots are released and never sampled
// timing assumes a 200 MHz clk; change clk_rate_mhz for other clocks
// frames are left aligned in cfg_frame_u and shifted out MSB first
// --------------------------------------------------------------------------
`default_nettype none

package cfg_pkg;

   // bus timing
   localparam int clk_rate_mhz  = 200;
   localparam int scl_period_ns = 2500;
   localparam int phase_cycles  = clk_rate_mhz * scl_period_ns / 2000;  // half SCL period
   localparam int phase_cnt_w   = $clog2(phase_cycles + 1);

   // sized compare values for the phase counter
   localparam logic [phase_cnt_w-1:0] phase_cnt_max = phase_cnt_w'(phase_cycles);
   localparam logic [phase_cnt_w-1:0] phase_cnt_mid = phase_cnt_w'(phase_cycles / 2);

   // frame layout
   localparam int frame_w        = 28;  // addr, rw, ack, reg, ack, data, ack, stop
   localparam int switch_frame_w = 19;  // addr, rw, ack, mask, ack, stop
   localparam int frame_len_w    = 5;
   localparam int num_frames     = 19;  // switch frame plus 18 register writes
   localparam int frame_idx_w    = 5;

   localparam logic [frame_len_w-1:0] frame_len        = frame_len_w'(frame_w);
   localparam logic [frame_len_w-1:0] switch_frame_len = frame_len_w'(switch_frame_w);
   localparam logic [frame_idx_w-1:0] last_frame_idx   = frame_idx_w'(num_frames - 1);

   // device addresses
   localparam logic [6:0] switch_addr         = 7'h74;
   localparam logic [7:0] switch_channel_mask = 8'h20;  // HDMI channel of the bus switch
   localparam logic [6:0] xmtr_addr           = 7'h39;

   // transmitter register table, written in this order
   localparam logic [7:0] cfg_reg_addr [18] = '{
      8'h41,  // power control
      8'h0B,  // spdif
      8'h14,  // audio word length
      8'h15,  // input video format
      8'h16,  // color depth and input edge
      8'h17,  // sync polarity
      8'h3C,  // VIC
      8'h0A,  // audio select
      8'h55,  // output format
      8'h73,  // audio channels
      8'h9D,  // pixel clock divide
      8'hAF,  // HDMI mode, no HDCP
      8'hD7,
      8'hD8,
      8'hD9,
      8'hDA,
      8'hDB,
      8'hF9   // fixed bus address
   };

   localparam logic [7:0] cfg_reg_data [18] = '{
      8'h10,  // powered up
      8'hC7,
      8'h02,
      8'h00,  // 24 bit RGB 4:4:4
      8'h32,
      8'h60,
      8'h02,
      8'h10,
      8'h00,  // RGB out
      8'h01,  // two channels
      8'h60,
      8'h06,
      8'h04,
      8'h03,
      8'hE0,
      8'h24,
      8'h06,
      8'h00
   };

   // one register write as it goes on the wire
   typedef struct packed {
      logic [6:0] dev_addr;
      logic       rw;
      logic       ack0;
      logic [7:0] reg_addr;
      logic       ack1;
      logic [7:0] data;
      logic       ack2;
      logic       stop;
   } cfg_frame_s;

   // built by fields, shifted out as flat bits
   typedef union packed {
      cfg_frame_s         fields;
      logic [frame_w-1:0] bits;
   } cfg_frame_u;

   typedef enum logic [2:0] {
      ph_idle,   // both lines high
      ph_start,  // sda low with scl high
      ph_low,    // scl low
      ph_setup,  // scl low, sda takes next bit
      ph_high    // scl high
   } bus_phase_t;

endpackage

`default_nettype wire

// ==== src/cfg_table.sv ====
// --------------------------------------------------------------------------
// frame builder, purely combinational
// index 0 is the bus switch frame, 1 to 18 the transmitter writes
// indices past the last frame are never requested
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cfg_table (
   input  logic [cfg_pkg::frame_idx_w-1:0] frame_idx,
   output cfg_pkg::cfg_frame_u             frame,
   output logic [cfg_pkg::frame_len_w-1:0] frame_bits
);

   logic [cfg_pkg::frame_idx_w-1:0] entry;  // table row for register frames

   assign entry = frame_idx - 1'b1;

   always_comb begin
      frame      = '0;
      frame_bits = cfg_pkg::frame_len;
      if (frame_idx == '0) begin
         // switch frame, left aligned
         frame.fields.dev_addr = cfg_pkg::switch_addr;
         frame.fields.rw       = 1'b0;                          // write
         frame.fields.ack0     = 1'b1;                          // line released
         frame.fields.reg_addr = cfg_pkg::switch_channel_mask;
         frame.fields.ack1     = 1'b1;
         frame.fields.data[7]  = 1'b0;                          // stop bit slot
         frame_bits            = cfg_pkg::switch_frame_len;
      end else begin
         frame.fields.dev_addr = cfg_pkg::xmtr_addr;
         frame.fields.rw       = 1'b0;
         frame.fields.ack0     = 1'b1;
         frame.fields.reg_addr = cfg_pkg::cfg_reg_addr[entry];
         frame.fields.ack1     = 1'b1;
         frame.fields.data     = cfg_pkg::cfg_reg_data[entry];
         frame.fields.ack2     = 1'b1;
         frame.fields.stop     = 1'b0;  // low so the stop rise shows
      end
   end

endmodule

`default_nettype wire

// ==== src/bus_bit_engine.sv ====
// --------------------------------------------------------------------------
// SDA/SCL line registers and frame shifter
// a new frame is taken every clock of ph_idle, so it must be stable there
// line outputs lag the bus phase by one clock
// frames are assumed longer than one bit
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module bus_bit_engine (
   input  logic                            clk,
   input  logic                            rst,
   input  cfg_pkg::bus_phase_t             bus_phase,
   input  logic                            phase_end,
   input  logic                            phase_mid,
   input  cfg_pkg::cfg_frame_u             frame,
   input  logic [cfg_pkg::frame_len_w-1:0] frame_bits,
   output logic                            frame_last,
   output logic                            scl,
   output logic                            sda
);

   logic [cfg_pkg::frame_w-1:0]     shreg;    // msb is the bit on the bus
   logic [cfg_pkg::frame_len_w-1:0] len_q;
   logic [cfg_pkg::frame_len_w-1:0] bit_cnt;  // bits already clocked out
   logic                            load;
   logic                            shift;

   assign load  = (bus_phase == cfg_pkg::ph_idle);
   assign shift = (bus_phase == cfg_pkg::ph_high) && phase_end;  // after scl high

   // frame payload
   always_ff @(posedge clk) begin
      if (load) begin
         shreg <= frame.bits;
         len_q <= frame_bits;
      end else if (shift) begin
         shreg <= {shreg[cfg_pkg::frame_w-2:0], 1'b0};
      end
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         bit_cnt    <= '0;
         frame_last <= 1'b0;
      end else if (load) begin
         bit_cnt    <= '0;
         frame_last <= 1'b0;
      end else if (shift) begin
         bit_cnt    <= bit_cnt + 1'b1;
         frame_last <= (bit_cnt + 2'd2 == len_q);  // next bit is the final one
      end
   end

   // line drivers
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         scl <= 1'b1;
         sda <= 1'b1;
      end else begin
         case (bus_phase)
            cfg_pkg::ph_idle: begin
               scl <= 1'b1;
               sda <= 1'b1;
            end
            cfg_pkg::ph_start: begin
               scl <= 1'b1;
               sda <= 1'b0;  // start condition
            end
            cfg_pkg::ph_low: begin
               scl <= 1'b0;
            end
            cfg_pkg::ph_setup: begin
               scl <= 1'b0;
               sda <= shreg[cfg_pkg::frame_w-1];
            end
            cfg_pkg::ph_high: begin
               scl <= 1'b1;
               if (phase_mid && frame_last)
                  sda <= 1'b1;  // stop, mid scl high
            end
            default: begin
               scl <= 1'b1;
               sda <= 1'b1;
            end
         endcase
      end
   end

   // counter must stay inside the loaded frame after each shift
   a_bit_cnt_range : assert property (@(posedge clk) disable iff (rst)
      shift |=> (bit_cnt <= frame_bits))
      else $error("bit counter %0d past frame length %0d", bit_cnt, frame_bits);

endmodule

`default_nettype wire

// ==== src/cfg_sequencer.sv ====
// --------------------------------------------------------------------------
// phase timer and frame level FSM
// every phase lasts phase_cycles + 1 clocks, the timer holds in st_done
// runs once after reset, restart only by reset
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module cfg_sequencer (
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            frame_last,
   output cfg_pkg::bus_phase_t             bus_phase,
   output logic                            phase_end,
   output logic                            phase_mid,
   output logic [cfg_pkg::frame_idx_w-1:0] frame_idx,
   output logic                            done
);

   typedef enum logic [2:0] {
      st_init,
      st_start,
      st_clk_fall,
      st_setup,
      st_clk_rise,
      st_wait,
      st_done
   } seq_state_t;

   seq_state_t                      state;
   seq_state_t                      state_nxt;
   logic [cfg_pkg::phase_cnt_w-1:0] phase_cnt;
   logic                            last_frame;

   assign phase_end  = (phase_cnt == cfg_pkg::phase_cnt_max);
   assign phase_mid  = (phase_cnt == cfg_pkg::phase_cnt_mid);
   assign last_frame = (frame_idx == cfg_pkg::last_frame_idx);

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         phase_cnt <= '0;
      else if (phase_end || state == st_done)
         phase_cnt <= '0;
      else
         phase_cnt <= phase_cnt + 1'b1;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         state <= st_init;
      else
         state <= state_nxt;
   end

   // all moves happen on the last clock of a phase
   always_comb begin
      state_nxt = state;
      if (phase_end) begin
         case (state)
            st_init:     state_nxt = st_start;
            st_start:    state_nxt = st_clk_fall;
            st_clk_fall: state_nxt = st_setup;
            st_setup:    state_nxt = st_clk_rise;
            st_clk_rise: state_nxt = frame_last ? st_wait : st_clk_fall;
            st_wait:     state_nxt = last_frame ? st_done : st_init;
            st_done:     state_nxt = st_done;
            default:     state_nxt = st_done;
         endcase
      end
   end

   always_comb begin
      case (state)
         st_start:    bus_phase = cfg_pkg::ph_start;
         st_clk_fall: bus_phase = cfg_pkg::ph_low;
         st_setup:    bus_phase = cfg_pkg::ph_setup;
         st_clk_rise: bus_phase = cfg_pkg::ph_high;
         default:     bus_phase = cfg_pkg::ph_idle;  // init, wait, done
      endcase
   end

   // next frame shows up while still in ph_idle
   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         frame_idx <= '0;
      else if (state == st_wait && phase_end && !last_frame)
         frame_idx <= frame_idx + 1'b1;
   end

   always_ff @(posedge clk or posedge rst) begin
      if (rst)
         done <= 1'b0;
      else
         done <= (state == st_done);
   end

   a_done_sticky : assert property (@(posedge clk) disable iff (rst)
      done |=> done)
      else $error("done fell before reset");

   a_frame_idx_range : assert property (@(posedge clk) disable iff (rst)
      frame_idx <= cfg_pkg::last_frame_idx)
      else $error("frame index %0d out of range", frame_idx);

endmodule

`default_nettype wire

// ==== src/i2c_cfg_top.sv ====
// --------------------------------------------------------------------------
// power up setup master for the HDMI transmitter
// scl and sda are push pull here, an open drain pad goes outside
// done stays high until the next reset
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module i2c_cfg_top (
   input  logic clk,
   input  logic rst,
   output logic scl,
   output logic sda,
   output logic done
);

   cfg_pkg::bus_phase_t             bus_phase;
   cfg_pkg::cfg_frame_u             frame;
   logic                            phase_end;
   logic                            phase_mid;
   logic                            frame_last;
   logic [cfg_pkg::frame_idx_w-1:0] frame_idx;
   logic [cfg_pkg::frame_len_w-1:0] frame_bits;

   cfg_sequencer u_cfg_sequencer (
      .clk        (clk),
      .rst        (rst),
      .frame_last (frame_last),
      .bus_phase  (bus_phase),
      .phase_end  (phase_end),
      .phase_mid  (phase_mid),
      .frame_idx  (frame_idx),
      .done       (done)
   );

   cfg_table u_cfg_table (
      .frame_idx  (frame_idx),
      .frame      (frame),
      .frame_bits (frame_bits)
   );

   bus_bit_engine u_bus_bit_engine (
      .clk        (clk),
      .rst        (rst),
      .bus_phase  (bus_phase),
      .phase_end  (phase_end),
      .phase_mid  (phase_mid),
      .frame      (frame),
      .frame_bits (frame_bits),
      .frame_last (frame_last),
      .scl        (scl),
      .sda        (sda)
   );

endmodule

`default_nettype wire

// ==== bench/tb_clock_gen.sv ====
// --------------------------------------------------------------------------
// free running testbench clock, 8 ns period, starts low
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen (
   output logic clk
);

   localparam int half_period = 4;  // ns

   initial clk = 1'b0;

   always #half_period clk = ~clk;

endmodule

`default_nettype wire

// ==== bench/tb_i2c_cfg.sv ====
// --------------------------------------------------------------------------
// testbench for the HDMI transmitter setup master
// a clocked bus monitor decodes frames and concurrent assertions check them
// lines are sampled on clk, so every level must last at least one clock
// expected frames are rebuilt from the package table
// --------------------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_i2c_cfg;

   localparam int phase_clks     = cfg_pkg::phase_cycles + 1;
   localparam int timeout_cycles = cfg_pkg::num_frames * 92 * phase_clks * 12 / 10;
   localparam int quiet_cycles   = 4 * phase_clks;  // watched after done

   logic clk;
   logic rst;
   logic scl;
   logic sda;
   logic done;

   // bus monitor state
   logic        scl_q     = 1'b1;
   logic        sda_q     = 1'b1;
   logic        done_q    = 1'b0;
   logic        started   = 1'b0;
   logic        in_frame  = 1'b0;
   logic [27:0] rx_bits   = '0;  // right aligned with the first bit highest
   int          rx_cnt    = 0;
   int          frame_cnt = 0;
   int          lvl_cnt   = 0;   // clocks scl has held its level
   logic        start_ev;
   logic        stop_ev;

   int err_cnt [1:5] = '{default: 0};
   int pass_cnt      = 0;
   int fail_cnt      = 0;
   int cycle_cnt     = 0;
   int idle_cycles;

   tb_clock_gen u_clock_gen (
      .clk (clk)
   );

   i2c_cfg_top u_i2c_cfg_top (
      .clk  (clk),
      .rst  (rst),
      .scl  (scl),
      .sda  (sda),
      .done (done)
   );

   // frame as it should appear on the wire with its stop slot
   function automatic logic [27:0] expected_frame(input int idx);
      logic [27:0] f;
      f = '0;
      if (idx == 0)
         f[18:0] = {cfg_pkg::switch_addr, 1'b0, 1'b1, cfg_pkg::switch_channel_mask,
                    1'b1, 1'b0};
      else
         f = {cfg_pkg::xmtr_addr, 1'b0, 1'b1, cfg_pkg::cfg_reg_addr[idx - 1], 1'b1,
              cfg_pkg::cfg_reg_data[idx - 1], 1'b1, 1'b0};
      return f;
   endfunction

   task automatic log_error(input int num, input string msg);
      err_cnt[num] = err_cnt[num] + 1;
      $display("ERR %0t: test %0d, %s", $time, num, msg);
   endtask

   task automatic report_result(input int num, input string name);
      if (err_cnt[num] == 0) begin
         pass_cnt = pass_cnt + 1;
         $display("test %0d %s: ok", num, name);
      end else begin
         fail_cnt = fail_cnt + 1;
         $display("test %0d %s: %0d errors", num, name, err_cnt[num]);
      end
   endtask

   assign start_ev = scl_q && scl && sda_q && !sda;
   assign stop_ev  = scl_q && scl && !sda_q && sda;

   always @(posedge clk) begin
      scl_q   <= scl;
      sda_q   <= sda;
      done_q  <= done;
      lvl_cnt <= (scl != scl_q) ? 1 : lvl_cnt + 1;
      if (start_ev) begin
         started  <= 1'b1;
         in_frame <= 1'b1;
         rx_bits  <= '0;
         rx_cnt   <= 0;
      end else if (stop_ev) begin
         in_frame  <= 1'b0;
         frame_cnt <= frame_cnt + 1;
      end else if (in_frame && !scl_q && scl) begin
         rx_bits <= {rx_bits[26:0], sda};  // sampled on scl rise
         rx_cnt  <= rx_cnt + 1;
      end
   end

   a_idle_lines : assert property (@(posedge clk) !started && !start_ev |->
      scl && sda && !done)
      else log_error(1, "bus lines or done not idle before the first start");

   a_switch_frame : assert property (@(posedge clk) stop_ev && frame_cnt == 0 |->
      rx_cnt == cfg_pkg::switch_frame_w && rx_bits == expected_frame(0))
      else log_error(2, $sformatf("switch frame %0d bits %h, expected %h",
                                  rx_cnt, rx_bits, expected_frame(0)));

   a_xmtr_frame : assert property (@(posedge clk)
      stop_ev && frame_cnt > 0 && frame_cnt < cfg_pkg::num_frames |->
      rx_cnt == cfg_pkg::frame_w && rx_bits == expected_frame(frame_cnt))
      else log_error(3, $sformatf("frame %0d got %0d bits %h, expected %h",
                                  $sampled(frame_cnt), rx_cnt, rx_bits,
                                  expected_frame($sampled(frame_cnt))));

   // sda may move under a high scl only as start or stop
   a_start_place : assert property (@(posedge clk) start_ev |-> !in_frame)
      else log_error(4, "start inside a frame");
   a_stop_place : assert property (@(posedge clk) stop_ev |-> in_frame)
      else log_error(4, "stop outside a frame");
   // stop rise lands half a phase into the last scl high
   a_stop_mid : assert property (@(posedge clk) stop_ev |->
      lvl_cnt == cfg_pkg::phase_cycles / 2)
      else log_error(4, $sformatf("stop after %0d clocks of scl high", $sampled(lvl_cnt)));
   a_scl_level : assert property (@(posedge clk) scl != scl_q |->
      lvl_cnt >= cfg_pkg::phase_cycles)
      else log_error(4, $sformatf("scl level held only %0d clocks", $sampled(lvl_cnt)));

   a_done_sticky : assert property (@(posedge clk) done_q |-> done)
      else log_error(5, "done fell");
   a_done_count : assert property (@(posedge clk) done |->
      frame_cnt == cfg_pkg::num_frames && !in_frame)
      else log_error(5, $sformatf("done with %0d frames seen", frame_cnt));
   a_bus_quiet : assert property (@(posedge clk) done |-> scl && sda && scl_q && sda_q)
      else log_error(5, "bus activity after done");
   a_no_extra : assert property (@(posedge clk) stop_ev |-> frame_cnt < cfg_pkg::num_frames)
      else log_error(5, "frame beyond the last table entry");

   always @(posedge clk) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= timeout_cycles) begin
         $display("timeout: done did not rise within %0d cycles", timeout_cycles);
         $display("Regression failed");
         $finish;
      end
   end

   initial begin
      rst <= 1'b1;
      void'($urandom(89));
      idle_cycles = int'($urandom % 21);
      repeat (8 + idle_cycles) @(posedge clk);
      rst <= 1'b0;
      while (!started) @(posedge clk);
      report_result(1, "idle lines before first start");
      while (frame_cnt < 1) @(posedge clk);
      report_result(2, "switch frame");
      while (frame_cnt < cfg_pkg::num_frames) @(posedge clk);
      report_result(3, "transmitter register frames");
      while (!done) @(posedge clk);
      repeat (quiet_cycles) @(posedge clk);
      report_result(4, "line timing, start and stop placement");
      report_result(5, "done and quiet bus");
      $display("tests passed %0d, failed %0d", pass_cnt, fail_cnt);
      if (fail_cnt == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   end

endmodule

`default_nettype wire

// ==== project.f ====
src/cfg_pkg.sv
src/cfg_table.sv
src/bus_bit_engine.sv
src/cfg_sequencer.sv
src/i2c_cfg_top.sv
bench/tb_clock_gen.sv
bench/tb_i2c_cfg.sv

// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert -Wno-fatal -j 0
TOP       = tb_i2c_cfg
FILELIST  = project.f
OBJ_DIR   = obj_dir
LOG       = sim.log

SIM  = $(OBJ_DIR)/V$(TOP)
SRCS = $(shell grep -v '^+' $(FILELIST))

.PHONY: all run clean

all: run

$(SIM): $(SRCS) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM)
	$(SIM) | tee $(LOG)
	@! grep -q "Regression failed" $(LOG) && grep -q "Regression passed" $(LOG)

clean:
	rm -rf $(OBJ_DIR) $(LOG)
